//--- files.f
design/periph_pkg.sv
design/sync_2ff.sv
design/apb_decoder.sv
design/gpio_regs.sv
design/sys_ctrl.sv
design/apb_response.sv
design/periph_subsys.sv
tests/periph_subsys_checker.sv
tests/periph_subsys_tb.sv

//--- tests/periph_subsys_tb.sv
`timescale 1ns/1ps

module periph_subsys_tb
   import periph_pkg::*;
();

   localparam int NUM   = 31;
   localparam int LIMIT = NUM * 10 + 20;

   logic        clk;
   logic        i_reset;
   logic        i_psel;
   logic        i_penable;
   logic        i_pwrite;
   apb_addr_t   i_paddr;
   word_t       i_pwdata;
   word_t       o_prdata;
   logic        o_pready;
   logic        o_pslverr;
   word_t       i_gpio_in;
   ram_status_t i_ram_status;
   word_t       o_gpio_out;
   word_t       o_gpio_oe;
   irq_vec_t    o_irq;

   int errors = 0;
   int cycles = 0;
   int n = 0;

   // Stimulus table
   string       t_name[NUM];
   word_t       t_pad[NUM];
   ram_status_t t_ram[NUM];
   logic        t_we[NUM];
   apb_addr_t   t_addr[NUM];
   word_t       t_wdata[NUM];
   word_t       t_rdata[NUM];
   logic        t_err[NUM];
   irq_vec_t    t_irq[NUM];
   logic        t_pads[NUM];

   periph_subsys i_periph_subsys (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr),
      .i_gpio_in    (i_gpio_in),
      .i_ram_status (i_ram_status),
      .o_gpio_out   (o_gpio_out),
      .o_gpio_oe    (o_gpio_oe),
      .o_irq        (o_irq)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Run stopped after %0d cycles without finishing the table", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic word_t xorshift32(input word_t x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic apb_addr_t gpio_addr(input reg_offset_t off);
      return {REGION_GPIO, off};
   endfunction

   function automatic apb_addr_t sys_addr(input reg_offset_t off);
      return {REGION_SYS, off};
   endfunction

   task automatic add_entry(input string name, input word_t pad, input ram_status_t ram,
                            input logic we, input apb_addr_t addr, input word_t wdata,
                            input word_t rdata, input logic err, input irq_vec_t irq,
                            input logic pads);
      t_name[n]  = name;
      t_pad[n]   = pad;
      t_ram[n]   = ram;
      t_we[n]    = we;
      t_addr[n]  = addr;
      t_wdata[n] = wdata;
      t_rdata[n] = rdata;
      t_err[n]   = err;
      t_irq[n]   = irq;
      t_pads[n]  = pads;
      n = n + 1;
   endtask

   task automatic check(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         errors = errors + 1;
         $display("ERROR %s expected %h actual %h", name, exp, act);
      end
   endtask

   // One APB transfer, held until the cycle after pready
   task automatic apb_xfer(input logic we, input apb_addr_t addr, input word_t wdata,
                           output word_t rdata, output logic err);
      @(negedge clk);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = we;
      i_paddr   = addr;
      i_pwdata  = wdata;
      @(negedge clk);
      i_penable = 1'b1;
      @(negedge clk);
      while (!o_pready) begin
         @(negedge clk);
      end
      rdata = o_prdata;
      err   = o_pslverr;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   initial begin
      word_t    rng;
      word_t    r_out;
      word_t    r_oe;
      word_t    r_pad;
      word_t    r_mask;
      word_t    pend_exp;
      irq_vec_t gi;
      word_t    rdata;
      logic     err;
      word_t    last_mtime;
      word_t    exp_out;
      word_t    exp_oe;
      int       assert_fails;

      clk          = 1'b0;
      i_reset      = 1'b1;
      i_psel       = 1'b0;
      i_penable    = 1'b0;
      i_pwrite     = 1'b0;
      i_paddr      = '0;
      i_pwdata     = '0;
      i_gpio_in    = '0;
      i_ram_status = '0;
      last_mtime   = '0;
      exp_out      = '0;
      exp_oe       = '0;

      rng    = xorshift32(32'd47597);
      r_out  = rng;
      rng    = xorshift32(rng);
      r_oe   = rng;
      rng    = xorshift32(rng);
      r_pad  = rng;
      rng    = xorshift32(rng);
      r_mask = rng;
      pend_exp = r_pad & r_mask;
      gi       = {2'b00, |pend_exp, 1'b0};

      // ****************************************
      // Entry columns are name, pad, ram, we, addr, wdata, rdata, err, irq and pads
      // ****************************************
      add_entry("out_wr", 0, 2'b01, 1, gpio_addr(GPIO_OUT), r_out, 0, 0, 4'b0000, 1);
      add_entry("oe_wr", 0, 2'b01, 1, gpio_addr(GPIO_OE), r_oe, 0, 0, 4'b0000, 1);
      add_entry("out_rd", 0, 2'b01, 0, gpio_addr(GPIO_OUT), 0, r_out, 0, 4'b0000, 1);
      add_entry("oe_rd", 0, 2'b01, 0, gpio_addr(GPIO_OE), 0, r_oe, 0, 4'b0000, 1);
      add_entry("in_rd", r_pad, 2'b01, 0, gpio_addr(GPIO_IN), 0, r_pad, 0, 4'b0000, 0);
      add_entry("mask_wr", r_pad, 2'b01, 1, gpio_addr(GPIO_MASK), r_mask, 0, 0, 4'b0000, 0);
      add_entry("pad_low", 0, 2'b01, 0, gpio_addr(GPIO_IN), 0, 0, 0, 4'b0000, 0);
      add_entry("pad_rise", r_pad, 2'b01, 0, gpio_addr(GPIO_IN), 0, r_pad, 0, gi, 0);
      add_entry("pend_rd", r_pad, 2'b01, 0, gpio_addr(GPIO_PEND), 0, pend_exp, 0, gi, 0);
      add_entry("pend_clr", r_pad, 2'b01, 1, gpio_addr(GPIO_PEND), pend_exp, 0, 0, 4'b0000, 0);
      add_entry("pend_rd0", r_pad, 2'b01, 0, gpio_addr(GPIO_PEND), 0, 0, 0, 4'b0000, 0);
      add_entry("version", r_pad, 2'b01, 0, sys_addr(SYS_VERSION), 0, SYS_VERSION_VALUE, 0,
                4'b0000, 0);
      add_entry("sw3_wr", r_pad, 2'b01, 1, sys_addr(SYS_SWIRQ), 1, 0, 0, 4'b0100, 0);
      add_entry("sw3_rd", r_pad, 2'b01, 0, sys_addr(SYS_SWIRQ), 0, 1, 0, 4'b0100, 0);
      add_entry("sw4_wr", r_pad, 2'b01, 1, sys_addr(SYS_SWIRQ), 2, 0, 0, 4'b1000, 0);
      add_entry("sw_clr", r_pad, 2'b01, 1, sys_addr(SYS_SWIRQ), 0, 0, 0, 4'b0000, 0);
      add_entry("status_done", r_pad, 2'b01, 0, sys_addr(SYS_STATUS), 0, 1, 0, 4'b0000, 0);
      add_entry("status_err", r_pad, 2'b10, 0, sys_addr(SYS_STATUS), 0, 2, 0, 4'b0000, 0);
      add_entry("cmp_zero", r_pad, 2'b01, 1, sys_addr(SYS_MTIMECMP), 0, 0, 0, 4'b0001, 0);
      add_entry("mtime_rd1", r_pad, 2'b01, 0, sys_addr(SYS_MTIME), 0, 0, 0, 4'b0001, 0);
      add_entry("mtime_rd2", r_pad, 2'b01, 0, sys_addr(SYS_MTIME), 0, 0, 0, 4'b0001, 0);
      add_entry("cmp_ones", r_pad, 2'b01, 1, sys_addr(SYS_MTIMECMP), '1, 0, 0, 4'b0000, 0);
      add_entry("cmp_rd", r_pad, 2'b01, 0, sys_addr(SYS_MTIMECMP), 0, '1, 0, 4'b0000, 0);
      add_entry("unmap_rd", r_pad, 2'b01, 0, 12'h200, 0, 0, 1, 4'b0000, 0);
      add_entry("unmap_wr", r_pad, 2'b01, 1, 12'h200, ~r_out, 0, 1, 4'b0000, 1);
      add_entry("unmap_wr2", r_pad, 2'b01, 1, 12'hF10, 0, 0, 1, 4'b0000, 1);
      add_entry("out_keep", r_pad, 2'b01, 0, gpio_addr(GPIO_OUT), 0, r_out, 0, 4'b0000, 1);
      add_entry("oe_keep", r_pad, 2'b01, 0, gpio_addr(GPIO_OE), 0, r_oe, 0, 4'b0000, 1);
      add_entry("mask_keep", r_pad, 2'b01, 0, gpio_addr(GPIO_MASK), 0, r_mask, 0, 4'b0000, 0);
      add_entry("cmp_keep", r_pad, 2'b01, 0, sys_addr(SYS_MTIMECMP), 0, '1, 0, 4'b0000, 0);
      add_entry("sw_keep", r_pad, 2'b01, 0, sys_addr(SYS_SWIRQ), 0, 0, 0, 4'b0000, 0);

      repeat (4) @(negedge clk);
      i_reset = 1'b0;

      for (int i = 0; i < NUM; i++) begin
         i_gpio_in    = t_pad[i];
         i_ram_status = t_ram[i];
         apb_xfer(t_we[i], t_addr[i], t_wdata[i], rdata, err);
         check({t_name[i], " pslverr"}, word_t'(t_err[i]), word_t'(err));
         if (!t_we[i]) begin
            if (t_addr[i] == sys_addr(SYS_MTIME)) begin
               check({t_name[i], " mtime_up"}, 32'd1, word_t'(rdata > last_mtime));
               last_mtime = rdata;
            end else begin
               check({t_name[i], " prdata"}, t_rdata[i], rdata);
            end
         end
         // Pad model follows mapped writes only
         if (t_we[i] && t_addr[i] == gpio_addr(GPIO_OUT)) begin
            exp_out = t_wdata[i];
         end
         if (t_we[i] && t_addr[i] == gpio_addr(GPIO_OE)) begin
            exp_oe = t_wdata[i];
         end
         check({t_name[i], " irq"}, word_t'(t_irq[i]), word_t'(o_irq));
         if (t_pads[i]) begin
            check({t_name[i], " gpio_out"}, exp_out, o_gpio_out);
            check({t_name[i], " gpio_oe"}, exp_oe, o_gpio_oe);
         end
      end

      assert_fails = i_periph_subsys.u_checker.fail_count;
      $display("Checks done, errors: %0d, assertion failures: %0d", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- tests/periph_subsys_checker.sv
`timescale 1ns/1ps

module periph_subsys_checker (
   input logic clk,
   input logic i_reset,
   input logic i_psel,
   input logic i_penable,
   input logic o_pready,
   input logic o_pslverr
);

   int fail_count = 0;

   // ****************************************
   // APB response rules
   // ****************************************
   a_pready_pulse: assert property (@(posedge clk) disable iff (i_reset)
      o_pready |=> !o_pready)
      else begin
         fail_count++;
         $error("pready stayed high for more than one cycle");
      end

   a_pready_access: assert property (@(posedge clk) disable iff (i_reset)
      o_pready |-> (i_psel && i_penable))
      else begin
         fail_count++;
         $error("pready outside an access phase");
      end

   a_pslverr_ready: assert property (@(posedge clk) disable iff (i_reset)
      o_pslverr |-> o_pready)
      else begin
         fail_count++;
         $error("pslverr without pready");
      end

   // Response is idle once reset has been seen
   a_reset_idle: assert property (@(posedge clk) i_reset |=> !o_pready)
      else begin
         fail_count++;
         $error("pready high right after reset");
      end

endmodule

bind periph_subsys periph_subsys_checker u_checker (
   .clk       (clk),
   .i_reset   (i_reset),
   .i_psel    (i_psel),
   .i_penable (i_penable),
   .o_pready  (o_pready),
   .o_pslverr (o_pslverr)
);

//--- design/periph_subsys.sv
`timescale 1ns/1ps

module periph_subsys
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_psel,
   input  logic        i_penable,
   input  logic        i_pwrite,
   input  apb_addr_t   i_paddr,
   input  word_t       i_pwdata,
   output word_t       o_prdata,
   output logic        o_pready,
   output logic        o_pslverr,
   input  word_t       i_gpio_in,
   input  ram_status_t i_ram_status,
   output word_t       o_gpio_out,
   output word_t       o_gpio_oe,
   output irq_vec_t    o_irq
);

   logic        gpio_req;
   logic        sys_req;
   logic        err_req;
   logic        we;
   reg_offset_t offset;
   word_t       wdata;
   logic        gpio_ack;
   logic        sys_ack;
   word_t       gpio_rdata;
   word_t       sys_rdata;
   logic        gpio_irq;
   logic        timer_irq;
   logic        sw_irq3;
   logic        sw_irq4;

   apb_decoder u_decoder (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .o_gpio_req (gpio_req),
      .o_sys_req  (sys_req),
      .o_err_req  (err_req),
      .o_we       (we),
      .o_offset   (offset),
      .o_wdata    (wdata)
   );

   gpio_regs u_gpio (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_req      (gpio_req),
      .i_we       (we),
      .i_offset   (offset),
      .i_wdata    (wdata),
      .i_gpio_in  (i_gpio_in),
      .o_ack      (gpio_ack),
      .o_rdata    (gpio_rdata),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_irq      (gpio_irq)
   );

   sys_ctrl u_sys (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_req        (sys_req),
      .i_we         (we),
      .i_offset     (offset),
      .i_wdata      (wdata),
      .i_ram_status (i_ram_status),
      .o_ack        (sys_ack),
      .o_rdata      (sys_rdata),
      .o_timer_irq  (timer_irq),
      .o_sw_irq3    (sw_irq3),
      .o_sw_irq4    (sw_irq4)
   );

   apb_response u_response (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_gpio_ack   (gpio_ack),
      .i_sys_ack    (sys_ack),
      .i_err_req    (err_req),
      .i_gpio_rdata (gpio_rdata),
      .i_sys_rdata  (sys_rdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr),
      .o_prdata     (o_prdata)
   );

   // Interrupt vector
   assign o_irq[IRQ_TIMER] = timer_irq;
   assign o_irq[IRQ_GPIO]  = gpio_irq;
   assign o_irq[IRQ_SW3]   = sw_irq3;
   assign o_irq[IRQ_SW4]   = sw_irq4;

endmodule

//--- design/apb_response.sv
`timescale 1ns/1ps

module apb_response
   import periph_pkg::*;
(
   input  logic  clk,
   input  logic  i_reset,
   input  logic  i_gpio_ack,
   input  logic  i_sys_ack,
   input  logic  i_err_req,
   input  word_t i_gpio_rdata,
   input  word_t i_sys_rdata,
   output logic  o_pready,
   output logic  o_pslverr,
   output word_t o_prdata
);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_pready  <= 1'b0;
         o_pslverr <= 1'b0;
      end else begin
         o_pready  <= i_gpio_ack || i_sys_ack || i_err_req;
         o_pslverr <= i_err_req;
      end
   end

   // Only one slave acks per transfer
   always_ff @(posedge clk) begin
      if (i_gpio_ack) begin
         o_prdata <= i_gpio_rdata;
      end else if (i_sys_ack) begin
         o_prdata <= i_sys_rdata;
      end else begin
         o_prdata <= '0;
      end
   end

endmodule

//--- design/sys_ctrl.sv
`timescale 1ns/1ps

module sys_ctrl
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_req,
   input  logic        i_we,
   input  reg_offset_t i_offset,
   input  word_t       i_wdata,
   input  ram_status_t i_ram_status,
   output logic        o_ack,
   output word_t       o_rdata,
   output logic        o_timer_irq,
   output logic        o_sw_irq3,
   output logic        o_sw_irq4
);

   ram_status_t ram_status_sync;
   logic [1:0]  sw_irq;
   word_t       mtime;
   word_t       mtimecmp;
   logic        wr;

   sync_2ff #(
      .payload_t (ram_status_t)
   ) u_status_sync (
      .clk     (clk),
      .i_reset (i_reset),
      .i_async (i_ram_status),
      .o_sync  (ram_status_sync)
   );

   assign wr = i_req && i_we;

   // ****************************************
   // Control registers and timer
   // ****************************************
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ack    <= 1'b0;
         sw_irq   <= 2'b00;
         mtime    <= '0;
         mtimecmp <= '1;
      end else begin
         o_ack <= i_req;
         mtime <= mtime + word_t'(1);
         if (wr) begin
            case (i_offset)
               SYS_SWIRQ:    sw_irq   <= i_wdata[1:0];
               SYS_MTIMECMP: mtimecmp <= i_wdata;
               default:      ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_req) begin
         case (i_offset)
            SYS_VERSION:  o_rdata <= SYS_VERSION_VALUE;
            SYS_SWIRQ:    o_rdata <= {{(DATA_W-2){1'b0}}, sw_irq};
            SYS_STATUS:   o_rdata <= {{(DATA_W-2){1'b0}}, ram_status_sync};
            SYS_MTIME:    o_rdata <= mtime;
            SYS_MTIMECMP: o_rdata <= mtimecmp;
            default:      o_rdata <= '0;
         endcase
      end
   end

   // Level interrupt while the compare point is reached
   assign o_timer_irq = (mtime >= mtimecmp);
   assign o_sw_irq3   = sw_irq[0];
   assign o_sw_irq4   = sw_irq[1];

endmodule

//--- design/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_req,
   input  logic        i_we,
   input  reg_offset_t i_offset,
   input  word_t       i_wdata,
   input  word_t       i_gpio_in,
   output logic        o_ack,
   output word_t       o_rdata,
   output word_t       o_gpio_out,
   output word_t       o_gpio_oe,
   output logic        o_irq
);

   word_t gpio_in_sync;
   word_t gpio_in_prev;
   word_t mask;
   word_t pend;
   word_t rise;
   word_t pend_clr;
   logic  wr;

   sync_2ff #(
      .payload_t (word_t)
   ) u_in_sync (
      .clk     (clk),
      .i_reset (i_reset),
      .i_async (i_gpio_in),
      .o_sync  (gpio_in_sync)
   );

   assign wr       = i_req && i_we;
   assign rise     = gpio_in_sync & ~gpio_in_prev & mask;
   assign pend_clr = (wr && (i_offset == GPIO_PEND)) ? i_wdata : '0;

   // ****************************************
   // Registers and edge detect
   // ****************************************
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ack        <= 1'b0;
         o_gpio_out   <= '0;
         o_gpio_oe    <= '0;
         mask         <= '0;
         pend         <= '0;
         gpio_in_prev <= '0;
      end else begin
         o_ack        <= i_req;
         gpio_in_prev <= gpio_in_sync;
         // A new edge wins over a clear in the same cycle
         pend         <= (pend & ~pend_clr) | rise;
         if (wr) begin
            case (i_offset)
               GPIO_OUT:  o_gpio_out <= i_wdata;
               GPIO_OE:   o_gpio_oe  <= i_wdata;
               GPIO_MASK: mask       <= i_wdata;
               default:   ;
            endcase
         end
      end
   end

   // Read mux
   always_ff @(posedge clk) begin
      if (i_req) begin
         case (i_offset)
            GPIO_OUT:  o_rdata <= o_gpio_out;
            GPIO_OE:   o_rdata <= o_gpio_oe;
            GPIO_IN:   o_rdata <= gpio_in_sync;
            GPIO_MASK: o_rdata <= mask;
            GPIO_PEND: o_rdata <= pend;
            default:   o_rdata <= '0;
         endcase
      end
   end

   assign o_irq = |pend;

endmodule

//--- design/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_psel,
   input  logic        i_penable,
   input  logic        i_pwrite,
   input  apb_addr_t   i_paddr,
   input  word_t       i_pwdata,
   output logic        o_gpio_req,
   output logic        o_sys_req,
   output logic        o_err_req,
   output logic        o_we,
   output reg_offset_t o_offset,
   output word_t       o_wdata
);

   logic                busy;
   logic                start;
   logic [REGION_W-1:0] region;

   // First access-phase edge only
   assign start  = i_psel && i_penable && !busy;
   assign region = i_paddr[REGION_HI:REGION_LO];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         busy       <= 1'b0;
         o_gpio_req <= 1'b0;
         o_sys_req  <= 1'b0;
         o_err_req  <= 1'b0;
      end else begin
         o_gpio_req <= start && (region == REGION_GPIO);
         o_sys_req  <= start && (region == REGION_SYS);
         o_err_req  <= start && (region != REGION_GPIO) && (region != REGION_SYS);
         // Held until the master leaves the access phase
         if (!i_penable) begin
            busy <= 1'b0;
         end else if (start) begin
            busy <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         o_we     <= i_pwrite;
         o_offset <= i_paddr[REGION_LO-1:0];
         o_wdata  <= i_pwdata;
      end
   end

endmodule

//--- design/sync_2ff.sv
`timescale 1ns/1ps

module sync_2ff #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     i_reset,
   input  payload_t i_async,
   output payload_t o_sync
);

   payload_t stage1;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         stage1 <= '0;
         o_sync <= '0;
      end else begin
         stage1 <= i_async;
         o_sync <= stage1;
      end
   end

endmodule

//--- design/periph_pkg.sv
package periph_pkg;

   // ****************************************
   // Widths
   // ****************************************
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 12;
   localparam int OFFSET_W = 8;
   localparam int IRQ_W    = 4;

   // Region select sits above the register offset
   localparam int REGION_LO = OFFSET_W;
   localparam int REGION_HI = ADDR_W - 1;
   localparam int REGION_W  = REGION_HI - REGION_LO + 1;

   typedef logic [DATA_W-1:0]   word_t;
   typedef logic [ADDR_W-1:0]   apb_addr_t;
   typedef logic [OFFSET_W-1:0] reg_offset_t;
   typedef logic [IRQ_W-1:0]    irq_vec_t;

   // Done lands in bit 0, error in bit 1
   typedef struct packed {
      logic ram_init_error;
      logic ram_init_done;
   } ram_status_t;

   // ****************************************
   // Address map
   // ****************************************
   localparam logic [REGION_W-1:0] REGION_GPIO = 4'h0;
   localparam logic [REGION_W-1:0] REGION_SYS  = 4'h1;

   localparam reg_offset_t GPIO_OUT  = 8'h00;
   localparam reg_offset_t GPIO_OE   = 8'h04;
   localparam reg_offset_t GPIO_IN   = 8'h08;
   localparam reg_offset_t GPIO_MASK = 8'h0C;
   localparam reg_offset_t GPIO_PEND = 8'h10;

   localparam reg_offset_t SYS_VERSION  = 8'h00;
   localparam reg_offset_t SYS_SWIRQ    = 8'h04;
   localparam reg_offset_t SYS_STATUS   = 8'h08;
   localparam reg_offset_t SYS_MTIME    = 8'h0C;
   localparam reg_offset_t SYS_MTIMECMP = 8'h10;

   localparam word_t SYS_VERSION_VALUE = 32'h0001_0A03;

   // Interrupt vector positions
   localparam int IRQ_TIMER = 0;
   localparam int IRQ_GPIO  = 1;
   localparam int IRQ_SW3   = 2;
   localparam int IRQ_SW4   = 3;

endpackage
